/* source/msoc_pkg.sv */
package msoc_pkg;

  // --------------------------------------------------
  // data bus and slot map
  // --------------------------------------------------
  localparam int XLEN     = 32;
  localparam int SLOT_MSB = 23;  // slot field is addr[23:20]
  localparam int SLOT_LSB = 20;

  localparam logic [3:0] SLOT_UART_CTRL = 4'd2;  // tx byte and baud
  localparam logic [3:0] SLOT_UART_RX   = 4'd3;  // rx status, write pops
  localparam logic [3:0] SLOT_GPIO      = 4'd7;  // led write, dip read

  // word offsets in the control slot, addr[5:2]
  localparam logic [3:0] OFS_TX_BYTE = 4'd0;
  localparam logic [3:0] OFS_BAUD    = 4'd1;

  localparam int                BAUD_W     = 11;
  localparam logic [BAUD_W-1:0] BAUD_RESET = 11'd54;  // clocks per bit minus one

  localparam int LED_W = 16;
  localparam int DIP_W = 8;

  // --------------------------------------------------
  // rx status word bit positions
  // --------------------------------------------------
  localparam int ST_DATA_LSB  = 0;   // fifo head byte
  localparam int ST_NOT_EMPTY = 8;
  localparam int ST_RX_BUSY   = 9;
  localparam int ST_TX_BUSY   = 10;
  localparam int ST_FRAME_ERR = 11;  // stop bit of head byte was low
  localparam int ST_FULL      = 12;
  localparam int ST_COUNT_LSB = 16;

endpackage

/* source/periph_bus.sv */
module periph_bus import msoc_pkg::*;
(
  input  logic              msoc_clk,
  input  logic              rstn,
  input  logic              bus_req_i,
  input  logic              bus_we_i,
  input  logic [XLEN-1:0]   bus_addr_i,
  input  logic [XLEN-1:0]   bus_wdata_i,
  input  logic [XLEN/8-1:0] bus_be_i,
  input  logic [DIP_W-1:0]  dip_i,
  input  logic [XLEN-1:0]   uart_status_i,
  output logic              bus_gnt_o,
  output logic              bus_rvalid_o,
  output logic [XLEN-1:0]   bus_rdata_o,
  output logic [LED_W-1:0]  led_o,
  output logic              uart_wr_o,
  output logic [3:0]        uart_ofs_o,
  output logic [XLEN-1:0]   uart_wdata_o,
  output logic              fifo_pop_o
);

  logic [15:0]      slot_sel;           // one-hot on addr[23:20]
  logic [XLEN-1:0]  slot_rdata [16];
  logic [XLEN-1:0]  rd_word;
  logic             wr_req;
  logic [DIP_W-1:0] dip_meta;
  logic [DIP_W-1:0] dip_sync;

  assign bus_gnt_o = bus_req_i;  // always ready
  assign wr_req    = bus_req_i & bus_we_i;

  // --------------------------------------------------
  // slot decode and read return
  // --------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < 16; i++)
      slot_sel[i] = (bus_addr_i[SLOT_MSB:SLOT_LSB] == i[3:0]);
  end

  always_comb
  begin
    for (int i = 0; i < 16; i++)
      slot_rdata[i] = '0;  // unmapped and control slot
    slot_rdata[SLOT_UART_RX] = uart_status_i;
    slot_rdata[SLOT_GPIO]    = {{(XLEN-DIP_W){1'b0}}, dip_sync};
  end

  always_comb
  begin
    rd_word = '0;
    for (int i = 0; i < 16; i++)
      rd_word |= slot_sel[i] ? slot_rdata[i] : '0;
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      bus_rvalid_o <= 1'b0;
      bus_rdata_o  <= '0;
    end
    else
    begin
      bus_rvalid_o <= bus_req_i;  // one pulse per request
      bus_rdata_o  <= (bus_req_i && !bus_we_i) ? rd_word : '0;
    end
  end

  // --------------------------------------------------
  // gpio
  // --------------------------------------------------
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
      led_o <= '0;
    else if (wr_req && slot_sel[SLOT_GPIO])
    begin
      for (int b = 0; b < LED_W/8; b++)
        if (bus_be_i[b])
          led_o[8*b +: 8] <= bus_wdata_i[8*b +: 8];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    dip_meta <= dip_i;     // switches are asynchronous
    dip_sync <= dip_meta;
  end

  // uart strobes, same cycle as the grant
  assign uart_wr_o    = wr_req & slot_sel[SLOT_UART_CTRL];
  assign uart_ofs_o   = bus_addr_i[5:2];
  assign uart_wdata_o = bus_wdata_i;
  assign fifo_pop_o   = wr_req & slot_sel[SLOT_UART_RX];

  // a valid pulse always answers a request granted the cycle before
  a_rvalid_after_gnt: assert property (@(posedge msoc_clk) disable iff (!rstn)
    bus_rvalid_o |-> $past(bus_req_i && bus_gnt_o));

endmodule

/* source/uart_regs.sv */
module uart_regs import msoc_pkg::*;
#(
  parameter int RX_FIFO_DEPTH = 4
)
(
  input  logic                           msoc_clk,
  input  logic                           rstn,
  input  logic                           uart_wr_i,
  input  logic [3:0]                     uart_ofs_i,
  input  logic [XLEN-1:0]                uart_wdata_i,
  input  logic [8:0]                     fifo_data_i,
  input  logic [$clog2(RX_FIFO_DEPTH):0] fifo_count_i,
  input  logic                           fifo_full_i,
  input  logic                           fifo_empty_i,
  input  logic                           tx_busy_i,
  input  logic                           rx_busy_i,
  output logic                           tx_start_o,
  output logic [7:0]                     tx_byte_o,
  output logic [BAUD_W-1:0]              baud_div_o,
  output logic [XLEN-1:0]                uart_status_o
);

  localparam int CNT_W = $clog2(RX_FIFO_DEPTH) + 1;

  logic wr_tx;
  logic wr_baud;

  assign wr_tx   = uart_wr_i && (uart_ofs_i == OFS_TX_BYTE);
  assign wr_baud = uart_wr_i && (uart_ofs_i == OFS_BAUD);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      tx_start_o <= 1'b0;
      baud_div_o <= BAUD_RESET;
    end
    else
    begin
      tx_start_o <= wr_tx;  // single cycle strobe
      if (wr_baud)
        baud_div_o <= uart_wdata_i[BAUD_W-1:0];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (wr_tx)
      tx_byte_o <= uart_wdata_i[7:0];
  end

  // status word, unused bits read zero
  always_comb
  begin
    uart_status_o                          = '0;
    uart_status_o[ST_DATA_LSB +: 8]        = fifo_data_i[7:0];
    uart_status_o[ST_NOT_EMPTY]            = ~fifo_empty_i;
    uart_status_o[ST_RX_BUSY]              = rx_busy_i;
    uart_status_o[ST_TX_BUSY]              = tx_busy_i;
    uart_status_o[ST_FRAME_ERR]            = fifo_data_i[8];
    uart_status_o[ST_FULL]                 = fifo_full_i;
    uart_status_o[ST_COUNT_LSB +: CNT_W]   = fifo_count_i;
  end

endmodule

/* source/uart_tx.sv */
module uart_tx import msoc_pkg::*;
(
  input  logic              msoc_clk,
  input  logic              rstn,
  input  logic              tx_start_i,
  input  logic [7:0]        tx_byte_i,
  input  logic [BAUD_W-1:0] baud_div_i,
  output logic              uart_tx_o,
  output logic              tx_busy_o
);

  logic [BAUD_W-1:0] div_cnt;
  logic [3:0]        bit_cnt;  // 0 start, 1..8 data, 9 stop
  logic [8:0]        frame;    // remaining data then stop, lsb first
  logic              load;
  logic              bit_end;

  assign load    = tx_start_i & ~tx_busy_o;  // start while busy is dropped
  assign bit_end = tx_busy_o & (div_cnt == baud_div_i);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      tx_busy_o <= 1'b0;
      uart_tx_o <= 1'b1;
      div_cnt   <= '0;
      bit_cnt   <= '0;
    end
    else if (load)
    begin
      tx_busy_o <= 1'b1;
      uart_tx_o <= 1'b0;  // start bit
      div_cnt   <= '0;
      bit_cnt   <= '0;
    end
    else if (tx_busy_o)
    begin
      if (bit_end)
      begin
        div_cnt <= '0;
        if (bit_cnt == 4'd9)
        begin
          tx_busy_o <= 1'b0;
          uart_tx_o <= 1'b1;
        end
        else
        begin
          bit_cnt   <= bit_cnt + 1'b1;
          uart_tx_o <= frame[0];
        end
      end
      else
        div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (load)
      frame <= {1'b1, tx_byte_i};
    else if (bit_end)
      frame <= {1'b1, frame[8:1]};
  end

  a_idle_high: assert property (@(posedge msoc_clk) disable iff (!rstn)
    !tx_busy_o |-> uart_tx_o);

endmodule

/* source/uart_rx.sv */
module uart_rx import msoc_pkg::*;
(
  input  logic              msoc_clk,
  input  logic              rstn,
  input  logic              uart_rx_i,
  input  logic [BAUD_W-1:0] baud_div_i,
  output logic              rx_valid_o,
  output logic [7:0]        rx_byte_o,
  output logic              rx_frame_err_o,
  output logic              rx_busy_o
);

  logic [2:0]        rx_hist;  // newest sample in bit 0
  logic              maj;
  logic              maj_q;
  logic [BAUD_W-1:0] div_cnt;
  logic [3:0]        bit_cnt;  // 0 start, 1..8 data, 9 stop
  logic              start_edge;
  logic              sample;

  // two of the last three samples win
  assign maj = (rx_hist[0] & rx_hist[1]) | (rx_hist[0] & rx_hist[2])
             | (rx_hist[1] & rx_hist[2]);

  assign start_edge = ~rx_busy_o & maj_q & ~maj;  // falling edge only
  assign sample     = rx_busy_o & (div_cnt == (baud_div_i >> 1));  // mid-bit

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_hist    <= 3'b111;  // idle line
      maj_q      <= 1'b1;
      rx_busy_o  <= 1'b0;
      rx_valid_o <= 1'b0;
      div_cnt    <= '0;
      bit_cnt    <= '0;
    end
    else
    begin
      rx_hist    <= {rx_hist[1:0], uart_rx_i};
      maj_q      <= maj;
      rx_valid_o <= 1'b0;
      if (start_edge)
      begin
        rx_busy_o <= 1'b1;
        div_cnt   <= '0;
        bit_cnt   <= '0;
      end
      else if (rx_busy_o)
      begin
        div_cnt <= (div_cnt == baud_div_i) ? '0 : div_cnt + 1'b1;
        if (sample)
        begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 4'd0 && maj)
            rx_busy_o <= 1'b0;  // glitch, not a start bit
          else if (bit_cnt == 4'd9)
          begin
            rx_busy_o  <= 1'b0;
            rx_valid_o <= 1'b1;
          end
        end
      end
    end
  end

  // start bit shifts in first and is pushed out by the 8 data bits
  always_ff @(posedge msoc_clk)
  begin
    if (sample)
    begin
      if (bit_cnt == 4'd9)
        rx_frame_err_o <= ~maj;  // stop bit must be high
      else
        rx_byte_o <= {maj, rx_byte_o[7:1]};
    end
  end

endmodule

/* source/rx_fifo.sv */
module rx_fifo
#(
  parameter int DEPTH = 4
)
(
  input  logic                   msoc_clk,
  input  logic                   rstn,
  input  logic                   push_i,
  input  logic [8:0]             push_data_i,
  input  logic                   pop_i,
  output logic [8:0]             head_o,
  output logic [$clog2(DEPTH):0] count_o,
  output logic                   full_o,
  output logic                   empty_o
);

  localparam int            AW       = $clog2(DEPTH);
  localparam logic [AW:0]   FULL_CNT = (AW+1)'(DEPTH);

  logic [8:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count_o == FULL_CNT);
  assign empty_o = (count_o == '0);
  assign do_push = push_i & ~full_o;   // overflow drops the byte
  assign do_pop  = pop_i & ~empty_o;
  assign head_o  = mem[rd_ptr];

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count_o <= count_o + 1'b1;
      else if (do_pop && !do_push)
        count_o <= count_o - 1'b1;
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data_i;
  end

  a_count_bound: assert property (@(posedge msoc_clk) disable iff (!rstn)
    count_o <= FULL_CNT);

endmodule

/* source/minion_periph_top.sv */
module minion_periph_top import msoc_pkg::*;
#(
  parameter int RX_FIFO_DEPTH = 4
)
(
  input  logic              msoc_clk,
  input  logic              rstn,
  input  logic              bus_req_i,
  input  logic              bus_we_i,
  input  logic [XLEN-1:0]   bus_addr_i,
  input  logic [XLEN-1:0]   bus_wdata_i,
  input  logic [XLEN/8-1:0] bus_be_i,
  output logic              bus_gnt_o,
  output logic              bus_rvalid_o,
  output logic [XLEN-1:0]   bus_rdata_o,
  input  logic              uart_rx_i,
  output logic              uart_tx_o,
  input  logic [DIP_W-1:0]  dip_i,
  output logic [LED_W-1:0]  led_o
);

  logic                           uart_wr;
  logic [3:0]                     uart_ofs;
  logic [XLEN-1:0]                uart_wdata;
  logic [XLEN-1:0]                uart_status;
  logic                           fifo_pop;
  logic                           tx_start;
  logic [7:0]                     tx_byte;
  logic [BAUD_W-1:0]              baud_div;
  logic                           tx_busy;
  logic                           rx_valid;
  logic [7:0]                     rx_byte;
  logic                           rx_frame_err;
  logic                           rx_busy;
  logic [8:0]                     fifo_head;  // frame error, byte
  logic [$clog2(RX_FIFO_DEPTH):0] fifo_count;
  logic                           fifo_full;
  logic                           fifo_empty;

  periph_bus u_periph_bus (
    .msoc_clk      (msoc_clk),
    .rstn          (rstn),
    .bus_req_i     (bus_req_i),
    .bus_we_i      (bus_we_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_be_i      (bus_be_i),
    .dip_i         (dip_i),
    .uart_status_i (uart_status),
    .bus_gnt_o     (bus_gnt_o),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .led_o         (led_o),
    .uart_wr_o     (uart_wr),
    .uart_ofs_o    (uart_ofs),
    .uart_wdata_o  (uart_wdata),
    .fifo_pop_o    (fifo_pop)
  );

  uart_regs #(.RX_FIFO_DEPTH(RX_FIFO_DEPTH)) u_uart_regs (
    .msoc_clk      (msoc_clk),
    .rstn          (rstn),
    .uart_wr_i     (uart_wr),
    .uart_ofs_i    (uart_ofs),
    .uart_wdata_i  (uart_wdata),
    .fifo_data_i   (fifo_head),
    .fifo_count_i  (fifo_count),
    .fifo_full_i   (fifo_full),
    .fifo_empty_i  (fifo_empty),
    .tx_busy_i     (tx_busy),
    .rx_busy_i     (rx_busy),
    .tx_start_o    (tx_start),
    .tx_byte_o     (tx_byte),
    .baud_div_o    (baud_div),
    .uart_status_o (uart_status)
  );

  uart_tx u_uart_tx (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .tx_start_i (tx_start),
    .tx_byte_i  (tx_byte),
    .baud_div_i (baud_div),
    .uart_tx_o  (uart_tx_o),
    .tx_busy_o  (tx_busy)
  );

  uart_rx u_uart_rx (
    .msoc_clk       (msoc_clk),
    .rstn           (rstn),
    .uart_rx_i      (uart_rx_i),
    .baud_div_i     (baud_div),
    .rx_valid_o     (rx_valid),
    .rx_byte_o      (rx_byte),
    .rx_frame_err_o (rx_frame_err),
    .rx_busy_o      (rx_busy)
  );

  rx_fifo #(.DEPTH(RX_FIFO_DEPTH)) u_rx_fifo (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .push_i      (rx_valid),
    .push_data_i ({rx_frame_err, rx_byte}),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .count_o     (fifo_count),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty)
  );

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen
#(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 2
)
(
  output logic msoc_clk,
  output logic rstn
);

  initial
  begin
    msoc_clk = 1'b0;
    forever #(PERIOD/2) msoc_clk = ~msoc_clk;
  end

  initial
  begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge msoc_clk);
    #1 rstn = 1'b1;  // release off the edge
  end

endmodule

/* tb/tb_minion_periph.sv */
module tb_minion_periph import msoc_pkg::*;
();

  localparam int          FIFO_DEPTH      = 4;
  localparam int          BAUD            = 7;
  localparam int          FRAME_CYCLES    = 10 * (BAUD + 1);
  localparam int          WATCHDOG_CYCLES = 40 * FRAME_CYCLES + 500;
  localparam logic [31:0] SEED            = 32'haf00ac74;
  // data field and frame error follow the fifo head entry
  localparam logic [31:0] HEAD_MASK = (32'hFF << ST_DATA_LSB) | (32'd1 << ST_FRAME_ERR);

  logic              msoc_clk;
  logic              rstn;
  logic              bus_req;
  logic              bus_we;
  logic [XLEN-1:0]   bus_addr;
  logic [XLEN-1:0]   bus_wdata;
  logic [XLEN/8-1:0] bus_be;
  logic              bus_gnt;
  logic              bus_rvalid;
  logic [XLEN-1:0]   bus_rdata;
  logic              uart_rx;
  logic              uart_tx;
  logic [DIP_W-1:0]  dip;
  logic [LED_W-1:0]  led;
  logic              loop_en;   // tx wired back to rx
  logic              rx_force;  // rx line when loop is broken

  assign uart_rx = loop_en ? uart_tx : rx_force;

  tb_clock_gen #(.PERIOD(8), .RST_CYCLES(2)) u_clock_gen (
    .msoc_clk (msoc_clk),
    .rstn     (rstn)
  );

  minion_periph_top #(.RX_FIFO_DEPTH(FIFO_DEPTH)) u_dut (
    .msoc_clk     (msoc_clk),
    .rstn         (rstn),
    .bus_req_i    (bus_req),
    .bus_we_i     (bus_we),
    .bus_addr_i   (bus_addr),
    .bus_wdata_i  (bus_wdata),
    .bus_be_i     (bus_be),
    .bus_gnt_o    (bus_gnt),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata),
    .uart_rx_i    (uart_rx),
    .uart_tx_o    (uart_tx),
    .dip_i        (dip),
    .led_o        (led)
  );

  // --------------------------------------------------
  // checking helpers
  // --------------------------------------------------
  task automatic report_fail(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
      report_fail($sformatf("ERR %s expected 0x%08h actual 0x%08h", name, exp, act));
  endtask

  a_gnt_same_cycle: assert property (@(posedge msoc_clk) disable iff (!rstn)
    bus_req |-> bus_gnt)
    else report_fail("a request was not granted in its own cycle");

  a_rvalid_next: assert property (@(posedge msoc_clk) disable iff (!rstn)
    bus_req |=> bus_rvalid)
    else report_fail("read-valid did not follow a granted request");

  a_rvalid_only_after_req: assert property (@(posedge msoc_clk) disable iff (!rstn)
    !bus_req |=> !bus_rvalid)
    else report_fail("read-valid pulsed without a request one cycle earlier");

  // --------------------------------------------------
  // bus tasks, entered and left 1 unit after an edge
  // --------------------------------------------------
  function automatic logic [31:0] reg_addr(input logic [3:0] slot, input logic [3:0] ofs);
    reg_addr                    = '0;
    reg_addr[SLOT_MSB:SLOT_LSB] = slot;
    reg_addr[5:2]               = ofs;
  endfunction

  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
    int waited;
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = wdata;
    bus_be    = be;
    @(posedge msoc_clk);
    #1;
    bus_req = 1'b0;
    bus_we  = 1'b0;
    waited  = 0;
    while (!bus_rvalid && waited < 4)
    begin
      @(posedge msoc_clk);
      #1;
      waited++;
    end
    if (!bus_rvalid)
      report_fail("no read-valid pulse after a granted request");
    else
      rdata = bus_rdata;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    logic [31:0] ignored;
    bus_access(1'b1, addr, wdata, be, ignored);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    bus_access(1'b0, addr, '0, 4'hf, rdata);
  endtask

  // two reads in consecutive cycles, both in flight
  task automatic bus_read_pair(input logic [31:0] addr_a, input logic [31:0] addr_b,
                               output logic [31:0] data_a, output logic [31:0] data_b);
    bus_req  = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr_a;
    @(posedge msoc_clk);
    #1;
    bus_addr = addr_b;
    data_a   = bus_rdata;
    @(posedge msoc_clk);
    #1;
    bus_req = 1'b0;
    data_b  = bus_rdata;
  endtask

  task automatic read_status(output logic [31:0] st);
    bus_read(reg_addr(SLOT_UART_RX, 4'd0), st);
  endtask

  task automatic pop_byte();
    bus_write(reg_addr(SLOT_UART_RX, 4'd0), '0, 4'hf);
  endtask

  task automatic send_byte(input logic [7:0] data);
    bus_write(reg_addr(SLOT_UART_CTRL, OFS_TX_BYTE), 32'(data), 4'hf);
    @(posedge msoc_clk);  // tx_busy shows one cycle after the strobe
    #1;
  endtask

  task automatic wait_uart_idle();
    logic [31:0] st;
    read_status(st);
    while (st[ST_TX_BUSY] || st[ST_RX_BUSY])
      read_status(st);
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial
  begin : stimulus
    logic [31:0] rd;
    logic [31:0] rd2;
    logic [31:0] st;
    logic [31:0] wd;
    logic [31:0] led_exp;
    logic [7:0]  sent [6];
    logic [7:0]  dip_val;
    int          busy_cycles;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_be    = '0;
    dip       = '0;
    loop_en   = 1'b1;
    rx_force  = 1'b1;
    void'($urandom(SEED));
    @(posedge rstn);
    @(posedge msoc_clk);
    #1;

    // idle after reset
    check_eq("idle line", 32'd1, 32'(uart_tx));
    read_status(st);
    check_eq("idle status", '0, st & ~HEAD_MASK);
    bus_write(reg_addr(SLOT_UART_CTRL, OFS_BAUD), 32'(BAUD), 4'hf);
    read_status(st);
    check_eq("tx busy after baud write", '0, 32'(st[ST_TX_BUSY]));

    // led byte enables
    wd = $urandom;
    bus_write(reg_addr(SLOT_GPIO, 4'd0), wd, 4'b0011);
    led_exp = {16'b0, wd[15:0]};
    check_eq("led both bytes", led_exp, 32'(led));
    wd = $urandom;
    bus_write(reg_addr(SLOT_GPIO, 4'd0), wd, 4'b0010);
    led_exp[15:8] = wd[15:8];
    check_eq("led upper byte", led_exp, 32'(led));
    wd = $urandom;
    bus_write(reg_addr(SLOT_GPIO, 4'd0), wd, 4'b1101);  // bytes 2,3 are not led
    led_exp[7:0] = wd[7:0];
    check_eq("led lower byte", led_exp, 32'(led));

    // dip through the two input registers
    dip_val = 8'($urandom);
    dip     = dip_val;
    repeat (2) @(posedge msoc_clk);
    #1;
    bus_read(reg_addr(SLOT_GPIO, 4'd0), rd);
    check_eq("dip read", 32'(dip_val), rd);

    // unmapped and control slots, single and back to back
    bus_read(reg_addr(4'd5, 4'd0), rd);
    check_eq("unmapped read", '0, rd);
    bus_read(reg_addr(SLOT_UART_CTRL, OFS_BAUD), rd);
    check_eq("control slot read", '0, rd);
    bus_read_pair(reg_addr(SLOT_GPIO, 4'd0), reg_addr(4'd9, 4'd3), rd, rd2);
    check_eq("back to back first", 32'(dip_val), rd);
    check_eq("back to back second", '0, rd2);

    // --------------------------------------------------
    // loopback of one byte
    // --------------------------------------------------
    sent[0] = 8'($urandom);
    send_byte(sent[0]);
    busy_cycles = 0;
    read_status(st);
    while (st[ST_TX_BUSY])
    begin
      busy_cycles++;
      read_status(st);
    end
    check_eq("tx busy cycles", FRAME_CYCLES, busy_cycles);
    while (!st[ST_NOT_EMPTY])
      read_status(st);
    check_eq("loopback status",
             32'(sent[0]) | (32'd1 << ST_NOT_EMPTY) | (32'd1 << ST_COUNT_LSB), st);
    pop_byte();
    read_status(st);
    check_eq("empty after pop", '0, st & ~HEAD_MASK);

    // overflow, last two bytes dropped
    for (int i = 0; i < 6; i++)
    begin
      sent[i] = 8'($urandom);
      send_byte(sent[i]);
      wait_uart_idle();
    end
    read_status(st);
    check_eq("overflow status", 32'(sent[0]) | (32'd1 << ST_NOT_EMPTY) | (32'd1 << ST_FULL)
             | (32'(FIFO_DEPTH) << ST_COUNT_LSB), st);
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      read_status(st);
      check_eq($sformatf("fifo entry %0d", i), 32'(sent[i]), st & HEAD_MASK);
      pop_byte();
    end
    read_status(st);
    check_eq("empty after drain", '0, st & ~HEAD_MASK);

    // --------------------------------------------------
    // frame error, line held low past the stop bit
    // --------------------------------------------------
    loop_en  = 1'b0;
    rx_force = 1'b0;
    repeat (11 * (BAUD + 1)) @(posedge msoc_clk);
    #1;
    rx_force = 1'b1;
    loop_en  = 1'b1;
    read_status(st);
    while (!st[ST_NOT_EMPTY])
      read_status(st);
    check_eq("frame error status",
             (32'd1 << ST_NOT_EMPTY) | (32'd1 << ST_FRAME_ERR) | (32'd1 << ST_COUNT_LSB), st);
    pop_byte();
    read_status(st);
    check_eq("empty after frame error", '0, st & ~HEAD_MASK);

    $display("SIMULATION PASSED");
    $finish;
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge msoc_clk);
    report_fail($sformatf("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

/* files.f */
source/msoc_pkg.sv
source/periph_bus.sv
source/uart_regs.sv
source/uart_tx.sv
source/uart_rx.sv
source/rx_fifo.sv
source/minion_periph_top.sv
tb/tb_clock_gen.sv
tb/tb_minion_periph.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_minion_periph
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(wildcard source/*.sv tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
